/* filelist.f */
yzb_isa_pkg.sv
yzb_cfg_pkg.sv
yzb_dispatch.sv
yzb_lane.sv
yzb_collect.sv
yzb_top.sv
tb_yzb.sv

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module tb_yzb -f filelist.f

# the simulation result is taken from the log, not the exit status
./obj_dir/Vtb_yzb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

/* tb_yzb.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_yzb;

    import yzb_isa_pkg::*;
    import yzb_cfg_pkg::*;

    localparam int         N_LANE       = 4;
    localparam int         DEPTH        = 8;
    localparam int         DONE_TIMEOUT = 100;
    // standard OP major opcode, not ours.
    localparam logic [6:0] OPC_STD_OP   = 7'b0110011;

    logic              clk;
    logic              rstn;
    logic              instr_valid;
    instr_t            instr;
    logic [DATA_W-1:0] rs1;
    logic [DATA_W-1:0] rs2;
    logic [DATA_W-1:0] result;
    logic              done;

    int                n_checks;

    yzb_top #(
        .N_LANE        (N_LANE),
        .DEPTH         (DEPTH)
    ) i_yzb_top (
        .clk_i         (clk),
        .rstn_i        (rstn),
        .instr_valid_i (instr_valid),
        .instr_i       (instr),
        .rs1_i         (rs1),
        .rs2_i         (rs2),
        .result_o      (result),
        .done_o        (done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    task automatic fail_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        n_checks++;
        if (actual !== expected) begin
            $display("ERROR %0s: expected %08h, actual %08h", name, expected, actual);
            fail_run();
        end
    endtask

    // uop 8 is an ldx1 body under a foreign opcode.
    function automatic instr_t make_word(int uop, int lane);
        instr_t w;
        w        = '0;
        w.funct7 = 7'(lane);
        w.rs2    = 5'd2;
        w.rs1    = 5'd1;
        w.rd     = 5'd3;
        if (uop == 8) begin
            w.funct3 = 3'(UOP_LDX1);
            w.opcode = OPC_STD_OP;
        end else begin
            w.funct3 = 3'(uop);
            w.opcode = OPC_CUSTOM0;
        end
        return w;
    endfunction

    // hold the instruction until done, then one idle cycle.
    task automatic issue(input string name, input instr_t word,
                         input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b,
                         output logic [DATA_W-1:0] res, output int waited);
        int cycles;
        cycles = 0;
        @(posedge clk);
        instr_valid <= 1'b1;
        instr       <= word;
        rs1         <= a;
        rs2         <= b;
        @(negedge clk);
        while (!done) begin
            cycles++;
            if (cycles >= DONE_TIMEOUT) begin
                $display("done never rose within %0d cycles on test %0s", DONE_TIMEOUT, name);
                fail_run();
            end
            @(negedge clk);
        end
        res    = result;
        waited = cycles;
        @(posedge clk);
        instr_valid <= 1'b0;
    endtask

    // ------------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------------

    initial begin
        int                fd;
        int                n;
        int                uop;
        int                lane;
        int                chk;
        int                waited;
        string             line;
        string             name;
        logic [8*32-1:0]   name_raw;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] exp_v;
        logic [DATA_W-1:0] res;

        instr_valid = 1'b0;
        instr       = '0;
        rs1         = '0;
        rs2         = '0;
        rstn        = 1'b0;
        n_checks    = 0;

        fd = $fopen("yzb_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open yzb_tests.txt");
            fail_run();
        end

        repeat (8) @(posedge clk);
        rstn <= 1'b1;

        while (!$feof(fd)) begin
            if ($fgets(line, fd) == 0) begin
                break;
            end
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%s %d %d %h %h %d %h", name_raw, uop, lane, a, b, chk, exp_v);
            if (n != 7) begin
                $display("malformed line in yzb_tests.txt: %0s", line);
                fail_run();
            end
            name = $sformatf("%0s", name_raw);
            issue(name, make_word(uop, lane), a, b, res, waited);
            // loads, clears and foreign words finish in their first cycle.
            if (uop != int'(UOP_RUN) && uop != int'(UOP_RUNALL)) begin
                check_value({name, "_done_wait"}, '0, DATA_W'(waited));
            end
            if (chk != 0) begin
                check_value(name, exp_v, res);
            end
        end
        $fclose(fd);

        if (n_checks == 0) begin
            $display("no checks were read from yzb_tests.txt");
            fail_run();
        end else begin
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* yzb_cfg_pkg.sv */
`default_nettype none

package yzb_cfg_pkg;

    // ------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------

    // operand and accumulator width.
    localparam int DATA_W = 32;

    // largest lane depth the counters can describe.
    localparam int MAX_DEPTH = 16;

    // must hold MAX_DEPTH itself, not just an index.
    typedef logic [$clog2(MAX_DEPTH + 1)-1:0] cnt_t;

    // ------------------------------------------------------------------
    // lane interface
    // ------------------------------------------------------------------

    // command broadcast to all lanes.
    typedef struct packed {
        yzb_isa_pkg::uop_e  uop;
        logic [DATA_W-1:0]  op1;
        logic [DATA_W-1:0]  op2;
    } lane_cmd_t;

    // idle is high once every loaded pair has been consumed.
    typedef struct packed {
        logic [DATA_W-1:0]  acc;
        logic               idle;
    } lane_stat_t;

endpackage

`default_nettype wire

/* yzb_collect.sv */
`timescale 1ns/1ps
`default_nettype none

module yzb_collect #(
    parameter  int N_LANE = 4,
    localparam int SEL_W  = (N_LANE > 1) ? $clog2(N_LANE) : 1
) (
    input  yzb_cfg_pkg::lane_stat_t [N_LANE-1:0]  lane_stat_i,
    input  logic [SEL_W-1:0]                      sel_lane_i,
    input  logic                                  is_run_i,
    input  logic                                  is_runall_i,
    input  logic                                  is_known_i,

    output logic [yzb_cfg_pkg::DATA_W-1:0]        result_o,
    output logic                                  done_o
);

    import yzb_cfg_pkg::*;

    logic [DATA_W-1:0] sum;
    logic              all_idle;
    logic              run_one;
    logic              run_all;

    // ------------------------------------------------------------------
    // reduction over all lanes
    // ------------------------------------------------------------------

    // sum wraps at DATA_W.
    always_comb begin
        sum      = '0;
        all_idle = 1'b1;
        for (int k = 0; k < N_LANE; k++) begin
            sum      = sum + lane_stat_i[k].acc;
            all_idle = all_idle & lane_stat_i[k].idle;
        end
    end

    // ------------------------------------------------------------------
    // result and done
    // ------------------------------------------------------------------

    assign run_one = is_known_i && is_run_i;
    assign run_all = is_known_i && is_runall_i;

    assign result_o = run_all ? sum : lane_stat_i[sel_lane_i].acc;

    // anything that is not a run completes at once.
    always_comb begin
        done_o = 1'b1;
        if (run_one) begin
            done_o = lane_stat_i[sel_lane_i].idle;
        end else if (run_all) begin
            done_o = all_idle;
        end
    end

endmodule

`default_nettype wire

/* yzb_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module yzb_dispatch #(
    parameter  int N_LANE = 4,
    localparam int SEL_W  = (N_LANE > 1) ? $clog2(N_LANE) : 1
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic                              instr_valid_i,
    input  yzb_isa_pkg::instr_t               instr_i,
    input  logic [yzb_cfg_pkg::DATA_W-1:0]    rs1_i,
    input  logic [yzb_cfg_pkg::DATA_W-1:0]    rs2_i,
    input  logic                              done_i,

    output yzb_cfg_pkg::lane_cmd_t            lane_cmd_o,
    output logic [N_LANE-1:0]                 lane_valid_o,
    output logic [SEL_W-1:0]                  sel_lane_o,
    output logic                              is_run_o,
    output logic                              is_runall_o,
    output logic                              is_known_o
);

    import yzb_isa_pkg::*;
    import yzb_cfg_pkg::*;

    uop_e uop;
    logic is_ldclr;
    logic fire;
    logic issued_q;
    logic done_q;
    logic done_rise;

    // ------------------------------------------------------------------
    // decode
    // ------------------------------------------------------------------

    assign uop = uop_e'(instr_i.funct3);

    // low for foreign opcodes and when nothing is presented.
    assign is_known_o  = instr_valid_i && (instr_i.opcode == OPC_CUSTOM0);
    assign is_run_o    = (uop == UOP_RUN);
    assign is_runall_o = (uop == UOP_RUNALL);
    assign is_ldclr    = !(is_run_o || is_runall_o);

    assign sel_lane_o = SEL_W'(instr_i.funct7 % N_LANE);

    assign lane_cmd_o = '{uop: uop, op1: rs1_i, op2: rs2_i};

    // ------------------------------------------------------------------
    // one-shot issue
    // ------------------------------------------------------------------

    // a held load or clear goes out on its first cycle only.
    assign fire      = is_known_o && is_ldclr && !issued_q;
    assign done_rise = done_i && !done_q;

    always_comb begin
        lane_valid_o = '0;
        lane_valid_o[sel_lane_o] = fire;
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            issued_q <= 1'b0;
            done_q   <= 1'b1;
        end else begin
            done_q <= done_i;
            if (fire) begin
                issued_q <= 1'b1;
            end else if (!instr_valid_i || done_rise) begin
                issued_q <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    a_lane_valid_onehot: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        $onehot0(lane_valid_o)
    );

endmodule

`default_nettype wire

/* yzb_isa_pkg.sv */
`default_nettype none

package yzb_isa_pkg;

    // ------------------------------------------------------------------
    // custom instruction encoding
    // ------------------------------------------------------------------

    // custom-0 major opcode.
    localparam logic [6:0] OPC_CUSTOM0 = 7'b0001011;

    // uop carried in funct3.
    // there is no nop code; an idle lane just sees its valid bit low.
    typedef enum logic [2:0] {
        UOP_LDX1   = 3'd0,
        UOP_LDX2   = 3'd1,
        UOP_LDW1   = 3'd2,
        UOP_LDW2   = 3'd3,
        UOP_CLRX   = 3'd4,
        UOP_CLRW   = 3'd5,
        UOP_RUN    = 3'd6,
        UOP_RUNALL = 3'd7
    } uop_e;

    // plain r-type layout, msb first.
    // funct7 picks the lane.
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

endpackage

`default_nettype wire

/* yzb_lane.sv */
`timescale 1ns/1ps
`default_nettype none

module yzb_lane #(
    parameter int DEPTH = 8
) (
    input  logic                      clk_i,
    input  logic                      rstn_i,

    input  logic                      cmd_valid_i,
    input  yzb_cfg_pkg::lane_cmd_t    cmd_i,

    output yzb_cfg_pkg::lane_stat_t   stat_o
);

    import yzb_isa_pkg::*;
    import yzb_cfg_pkg::*;

    localparam int   AW      = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam cnt_t DEPTH_C = cnt_t'(DEPTH);

    // bank 0 is x, bank 1 is w.
    cnt_t              fill [2];
    logic [DATA_W-1:0] rd   [2];

    cnt_t              used_q;
    logic [DATA_W-1:0] acc_q;
    cnt_t              fill_min;
    logic              busy;

    logic              is_load;
    logic              is_clr;
    logic              pair;

    // count after one or two more writes, capped at the depth.
    function automatic cnt_t sat_add(cnt_t c, logic two);
        cnt_t n;
        n = c + cnt_t'(1) + cnt_t'(two);
        return (n > DEPTH_C) ? DEPTH_C : n;
    endfunction

    // ------------------------------------------------------------------
    // uop decode
    // ------------------------------------------------------------------

    // loads are codes 0 to 3.
    // bit 1 picks the bank and bit 0 marks a pair.
    assign is_load = (cmd_i.uop[2] == 1'b0);
    assign is_clr  = (cmd_i.uop == UOP_CLRX) || (cmd_i.uop == UOP_CLRW);
    assign pair    = cmd_i.uop[0];

    if (DEPTH > MAX_DEPTH) begin : g_depth_check
        $error("lane depth exceeds counter range");
    end

    // ------------------------------------------------------------------
    // operand banks
    // ------------------------------------------------------------------

    for (genvar b = 0; b < 2; b++) begin : g_bank
        localparam logic BANK = (b == 1);

        logic [DATA_W-1:0] mem_q [DEPTH];
        cnt_t              fill_q;
        cnt_t              slot1;
        logic              wr_hit;
        logic              clr_hit;

        assign wr_hit  = cmd_valid_i && is_load && (cmd_i.uop[1] == BANK);
        // clears use bit 0 for the bank.
        assign clr_hit = cmd_valid_i && is_clr && (cmd_i.uop[0] == BANK);
        assign slot1   = fill_q + cnt_t'(1);

        always_ff @(posedge clk_i) begin
            if (!rstn_i) begin
                fill_q <= '0;
            end else if (clr_hit) begin
                fill_q <= '0;
            end else if (wr_hit) begin
                fill_q <= sat_add(fill_q, pair);
            end
        end

        // writes past the end are dropped.
        always_ff @(posedge clk_i) begin
            if (wr_hit && (fill_q < DEPTH_C)) begin
                mem_q[fill_q[AW-1:0]] <= cmd_i.op1;
            end
            if (wr_hit && pair && (slot1 < DEPTH_C)) begin
                mem_q[slot1[AW-1:0]] <= cmd_i.op2;
            end
        end

        assign fill[b] = fill_q;
        assign rd[b]   = mem_q[used_q[AW-1:0]];

        a_fill_bound: assert property (
            @(posedge clk_i) disable iff (!rstn_i)
            fill_q <= DEPTH_C
        );
    end

    // ------------------------------------------------------------------
    // background mac
    // ------------------------------------------------------------------

    assign fill_min = (fill[0] < fill[1]) ? fill[0] : fill[1];
    assign busy     = (used_q < fill_min);

    // a clear throws away products taken from the old contents.
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            used_q <= '0;
            acc_q  <= '0;
        end else if (cmd_valid_i && is_clr) begin
            used_q <= '0;
            acc_q  <= '0;
        end else if (busy) begin
            used_q <= used_q + cnt_t'(1);
            acc_q  <= acc_q + rd[0] * rd[1];
        end
    end

    assign stat_o = '{acc: acc_q, idle: (used_q == fill_min)};

    a_used_le_fill: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        (used_q <= fill[0]) && (used_q <= fill[1])
    );

endmodule

`default_nettype wire

/* yzb_tests.txt */
# name uop lane rs1 rs2 check expected (rs1, rs2 and expected in hex)
# uop 0..7 is the funct3 code, 8 sends an ldx1 body under a foreign opcode
b1_ldx1        0 0 00000002 00000000 0 00000000
b1_ldx2        1 0 00000003 00000004 0 00000000
b1_ldw2        3 0 00000005 00000006 0 00000000
b1_ldw1        2 0 00000007 00000000 0 00000000
b1_run         6 0 00000000 00000000 1 00000038
b2_ldx2_a      1 1 00000001 00000002 0 00000000
b2_ldx2_b      1 1 00000003 00000004 0 00000000
b2_ldx1        0 1 00000005 00000000 0 00000000
b2_ldw1        2 1 0000000a 00000000 0 00000000
b2_run_one     6 1 00000000 00000000 1 0000000a
b2_ldw2_a      3 1 00000014 0000001e 0 00000000
b2_run_three   6 1 00000000 00000000 1 0000008c
b2_ldw2_b      3 1 00000028 00000032 0 00000000
b2_run_five    6 1 00000000 00000000 1 00000226
b2_ldw1_extra  2 1 0000003c 00000000 0 00000000
b2_run_capped  6 1 00000000 00000000 1 00000226
b3_clrx        4 0 00000000 00000000 0 00000000
b3_run_empty   6 0 00000000 00000000 1 00000000
b3_ldx2        1 0 0000000a 0000000b 0 00000000
b3_run_reload  6 0 00000000 00000000 1 00000074
b4_ldx1_l2     0 2 00010001 00000000 0 00000000
b4_ldw1_l2     2 2 00010001 00000000 0 00000000
b4_ldx1_l3     0 3 7fffffff 00000000 0 00000000
b4_ldw1_l3     2 3 00000002 00000000 0 00000000
b4_run_l0      6 0 00000000 00000000 1 00000074
b4_run_l1      6 1 00000000 00000000 1 00000226
b4_run_l2      6 2 00000000 00000000 1 00020001
b4_run_l3      6 3 00000000 00000000 1 fffffffe
b4_runall      7 0 00000000 00000000 1 00020299
b5_clrx        4 3 00000000 00000000 0 00000000
b5_clrw        5 3 00000000 00000000 0 00000000
b5_ldx2_a      1 3 00000001 00000002 0 00000000
b5_ldx2_b      1 3 00000003 00000004 0 00000000
b5_ldx2_c      1 3 00000005 00000006 0 00000000
b5_ldx2_d      1 3 00000007 00000008 0 00000000
b5_ldx2_e      1 3 00000009 0000000a 0 00000000
b5_ldw2_a      3 3 00000001 00000002 0 00000000
b5_ldw2_b      3 3 00000003 00000004 0 00000000
b5_ldw2_c      3 3 00000005 00000006 0 00000000
b5_ldw2_d      3 3 00000007 00000008 0 00000000
b5_ldw2_e      3 3 00000009 0000000a 0 00000000
b5_run         6 3 00000000 00000000 1 000000cc
b5_runall      7 0 00000000 00000000 1 00020367
b6_foreign     8 1 00000055 00000066 0 00000000
b6_run         6 1 00000000 00000000 1 00000226

/* yzb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module yzb_top #(
    parameter int N_LANE = 4,
    parameter int DEPTH  = 8
) (
    input  logic                              clk_i,
    input  logic                              rstn_i,

    input  logic                              instr_valid_i,
    input  yzb_isa_pkg::instr_t               instr_i,
    input  logic [yzb_cfg_pkg::DATA_W-1:0]    rs1_i,
    input  logic [yzb_cfg_pkg::DATA_W-1:0]    rs2_i,

    output logic [yzb_cfg_pkg::DATA_W-1:0]    result_o,
    output logic                              done_o
);

    import yzb_cfg_pkg::*;

    localparam int SEL_W = (N_LANE > 1) ? $clog2(N_LANE) : 1;

    lane_cmd_t                lane_cmd;
    logic [N_LANE-1:0]        lane_valid;
    lane_stat_t [N_LANE-1:0]  lane_stat;
    logic [SEL_W-1:0]         sel_lane;
    logic                     is_run;
    logic                     is_runall;
    logic                     is_known;

    yzb_dispatch #(
        .N_LANE        (N_LANE)
    ) i_dispatch (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_i         (rs1_i),
        .rs2_i         (rs2_i),
        .done_i        (done_o),
        .lane_cmd_o    (lane_cmd),
        .lane_valid_o  (lane_valid),
        .sel_lane_o    (sel_lane),
        .is_run_o      (is_run),
        .is_runall_o   (is_runall),
        .is_known_o    (is_known)
    );

    // one lane per index, all see the same command word.
    for (genvar k = 0; k < N_LANE; k++) begin : g_lane
        yzb_lane #(
            .DEPTH       (DEPTH)
        ) i_lane (
            .clk_i       (clk_i),
            .rstn_i      (rstn_i),
            .cmd_valid_i (lane_valid[k]),
            .cmd_i       (lane_cmd),
            .stat_o      (lane_stat[k])
        );
    end

    yzb_collect #(
        .N_LANE        (N_LANE)
    ) i_collect (
        .lane_stat_i   (lane_stat),
        .sel_lane_i    (sel_lane),
        .is_run_i      (is_run),
        .is_runall_i   (is_runall),
        .is_known_i    (is_known),
        .result_o      (result_o),
        .done_o        (done_o)
    );

endmodule

`default_nettype wire
